// File: quad_cmd_top.f
source/quad_cmd_pkg.sv
source/cmd_if.sv
source/uart_rx.sv
source/uart_tx.sv
source/cmd_assembler.sv
source/cmd_cfg.sv
source/quad_cmd_top.sv
bench/tb_clock.sv
bench/quad_cmd_tb.sv

// File: Bender.yml
package:
  name: quad_cmd

sources:
  - files:
      - source/quad_cmd_pkg.sv
      - source/cmd_if.sv
      - source/uart_rx.sv
      - source/uart_tx.sv
      - source/cmd_assembler.sv
      - source/cmd_cfg.sv
      - source/quad_cmd_top.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/quad_cmd_tb.sv

// File: bench/quad_cmd_tb.sv
`timescale 1ns/100ps
// testbench for quad_cmd_top, sends serial commands, decodes the serial acks and checks the outputs
module quad_cmd_tb
    import quad_cmd_pkg::*;
();

    localparam int CMD_TIMEOUT  = 35 * BAUD_DIV;         // a full command plus decode latency
    localparam int RAMP_TIMEOUT = 2 ** CAL_TMR_W + 20;
    localparam int ACK_TIMEOUT  = 4 * BAUD_DIV;          // ack after cal_done starts quickly

    logic clk, rst_n;
    logic rx, cal_done, tx;
    logic [15:0] d_ptch, d_roll, d_yaw;
    logic [8:0]  thrst;
    logic strt_cal, inertial_cal, motors_off;

    logic [7:0]  resp_byte;    // last byte seen on tx
    logic        resp_valid;   // one cycle per decoded byte
    logic [31:0] rng_state;
    logic [15:0] exp_ptch, exp_roll, exp_yaw;  // reference model of the setpoints
    logic [8:0]  exp_thrst;
    logic        exp_motors_off;

    tb_clock clk_gen (.clk(clk), .rst_n(rst_n));

    quad_cmd_top UUT (
        .clk(clk), .rst_n(rst_n), .rx(rx), .cal_done(cal_done), .tx(tx),
        .d_ptch(d_ptch), .d_roll(d_roll), .d_yaw(d_yaw), .thrst(thrst),
        .strt_cal(strt_cal), .inertial_cal(inertial_cal), .motors_off(motors_off)
    );

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
        assert (act === exp) else
            stop_on_error($sformatf("CHECK FAILED at %0d ns: %s expected %h, got %h",
                                    $time, name, exp, act));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic next_random(output logic [15:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state[15:0];
    endtask

    // one 8N1 frame, lsb first, each bit held for a full bit time
    task automatic send_uart_byte(input logic [7:0] b);
        logic [9:0] bits;
        bits = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx <= bits[i];
            repeat (BAUD_DIV - 1) @(posedge clk);
        end
    endtask

    task automatic send_command(input logic [7:0] op, input logic [15:0] data);
        send_uart_byte(op);
        send_uart_byte(data[15:8]);  // high byte goes first
        send_uart_byte(data[7:0]);
    endtask

    // waits for a start bit, then samples tx at each bit center
    task automatic receive_response(input int timeout);
        int t;
        logic [7:0] b;
        t = 0;
        do begin
            @(negedge clk);
            t++;
            if (t > timeout)
                stop_on_error("no response start bit appeared on tx");
        end while (tx !== 1'b0);
        repeat (BAUD_DIV / 2 - 1) @(negedge clk);  // middle of start bit
        check_value("tx start bit", 16'h0, {15'h0, tx});
        for (int i = 0; i < 8; i++) begin
            repeat (BAUD_DIV) @(negedge clk);
            b[i] = tx;
        end
        repeat (BAUD_DIV) @(negedge clk);
        check_value("tx stop bit", 16'h1, {15'h0, tx});
        @(posedge clk);
        resp_byte  <= b;  // checked by the response assertion
        resp_valid <= 1'b1;
        @(posedge clk);
        resp_valid <= 1'b0;
    endtask

    task automatic run_command(input logic [7:0] op, input logic [15:0] data);
        fork
            send_command(op, data);
            receive_response(CMD_TIMEOUT);  // ack starts during the last stop bit
        join
    endtask

    task automatic check_outputs();
        @(negedge clk);
        check_value("d_ptch", exp_ptch, d_ptch);
        check_value("d_roll", exp_roll, d_roll);
        check_value("d_yaw", exp_yaw, d_yaw);
        check_value("thrst", {7'h0, exp_thrst}, {7'h0, thrst});
        check_value("motors_off", {15'h0, exp_motors_off}, {15'h0, motors_off});
    endtask

    // setpoint command with fresh random data, model follows the addressed output
    task automatic write_setpoint(input logic [7:0] op);
        logic [15:0] r;
        next_random(r);
        run_command(op, r);
        case (op)
            8'h02:   exp_ptch  = r;
            8'h03:   exp_roll  = r;
            8'h04:   exp_yaw   = r;
            default: exp_thrst = r[8:0];  // thrust keeps the low 9 bits
        endcase
        check_outputs();
    endtask

    task automatic zero_model();
        exp_ptch  = '0;
        exp_roll  = '0;
        exp_yaw   = '0;
        exp_thrst = '0;
    endtask

    // ramp length is measured from the rise of inertial_cal to the strt_cal pulse
    task automatic measure_ramp();
        int t;
        int ramp;
        t = 0;
        do begin
            @(negedge clk);
            t++;
            if (t > CMD_TIMEOUT)
                stop_on_error("inertial_cal never rose after CALIBRATE");
        end while (inertial_cal !== 1'b1);
        ramp = 0;
        do begin
            @(negedge clk);
            ramp++;
            if (ramp > RAMP_TIMEOUT)
                stop_on_error("strt_cal never pulsed after the motor ramp");
        end while (strt_cal !== 1'b1);
        check_value("strt_cal delay", 16'(2 ** CAL_TMR_W + 1), 16'(ramp));
        check_value("motors_off", 16'h0, {15'h0, motors_off});
    endtask

    // no second ack may follow
    task automatic expect_line_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            if (tx !== 1'b1)
                stop_on_error("unexpected extra frame on tx");
        end
    endtask

    a_tx_bit_time: assert property (
        @(posedge clk) disable iff (!rst_n)
        $fell(tx) |-> !tx [* BAUD_DIV]
    ) else stop_on_error($sformatf("CHECK FAILED at %0d ns: tx expected 0, got 1", $time));

    a_resp_ack: assert property (
        @(posedge clk) disable iff (!rst_n)
        resp_valid |-> resp_byte == 8'hA5
    ) else stop_on_error($sformatf("CHECK FAILED at %0d ns: resp_byte expected a5, got %h",
                                   $time, resp_byte));

    a_strt_cal_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        strt_cal |=> !strt_cal
    ) else stop_on_error($sformatf("CHECK FAILED at %0d ns: strt_cal expected 0, got 1", $time));

    // calibrate ack is held until cal_done
    a_quiet_in_cal: assert property (
        @(posedge clk) disable iff (!rst_n)
        (inertial_cal && !cal_done) |-> tx
    ) else stop_on_error($sformatf("CHECK FAILED at %0d ns: tx expected 1, got 0", $time));

    initial begin
        int t;
        logic [15:0] r;
        rx         <= 1'b1;  // line idles high
        cal_done   <= 1'b0;
        resp_byte  <= 8'h00;
        resp_valid <= 1'b0;
        rng_state  = 32'he678_0a8b;
        zero_model();
        exp_motors_off = 1'b1;
        t = 0;
        do begin
            @(negedge clk);
            t++;
            if (t > 10)
                stop_on_error("rst_n was never released");
        end while (rst_n !== 1'b1);
        check_outputs();
        check_value("tx", 16'h1, {15'h0, tx});
        check_value("strt_cal", 16'h0, {15'h0, strt_cal});
        check_value("inertial_cal", 16'h0, {15'h0, inertial_cal});
        // setpoint writes, two rounds with fresh data
        repeat (2) begin
            write_setpoint(8'h02);
            write_setpoint(8'h03);
            write_setpoint(8'h04);
            write_setpoint(8'h05);
        end
        next_random(r);
        run_command(8'h07, r);  // emergency landing
        zero_model();
        check_outputs();
        write_setpoint(8'h02);
        write_setpoint(8'h05);
        next_random(r);
        run_command(8'h3c, r);  // unknown opcode lands as well
        zero_model();
        check_outputs();
        // calibration, ack only after cal_done
        next_random(r);
        fork
            send_command(8'h06, r);
            measure_ramp();
        join
        exp_motors_off = 1'b0;
        next_random(r);
        repeat (r[5:0] + 1) @(posedge clk);
        check_value("inertial_cal", 16'h1, {15'h0, inertial_cal});
        fork
            begin
                @(posedge clk);
                cal_done <= 1'b1;
                @(posedge clk);
                cal_done <= 1'b0;
            end
            receive_response(ACK_TIMEOUT);
        join
        check_value("inertial_cal", 16'h0, {15'h0, inertial_cal});
        expect_line_idle(12 * BAUD_DIV);
        check_outputs();
        next_random(r);
        run_command(8'h08, r);  // motors off again
        exp_motors_off = 1'b1;
        check_outputs();
        $display("TEST OK");
        $finish;
    end

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/100ps
// testbench clock and reset source, 100 ns clock with rst_n held low for the first three cycles
module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;  // released on the third rising edge
    end

endmodule

// File: source/quad_cmd_top.sv
`timescale 1ns/100ps
// command side top level, uart in, setpoints and calibration control out, ack byte back on tx
module quad_cmd_top
    import quad_cmd_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    rx,            // serial commands in
    input  logic    cal_done,      // from inertial unit
    output logic    tx,            // serial acks out
    output angle_t  d_ptch,
    output angle_t  d_roll,
    output angle_t  d_yaw,
    output thrust_t thrst,
    output logic    strt_cal,
    output logic    inertial_cal,
    output logic    motors_off
);

    logic  rx_rdy;     // byte strobe from the receiver
    byte_t rx_data;
    logic  send_resp;  // ack strobe to the transmitter
    byte_t resp;

    cmd_if cmd_bus ();  // assembler to command block

    uart_rx u_rx (
        .clk     (clk),
        .rst_n   (rst_n),
        .rx      (rx),
        .rx_rdy  (rx_rdy),
        .rx_data (rx_data)
    );

    cmd_assembler u_asm (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_rdy   (rx_rdy),
        .rx_data  (rx_data),
        .cmd_port (cmd_bus)
    );

    cmd_cfg u_cfg (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_port     (cmd_bus),
        .resp         (resp),
        .send_resp    (send_resp),
        .d_ptch       (d_ptch),
        .d_roll       (d_roll),
        .d_yaw        (d_yaw),
        .thrst        (thrst),
        .strt_cal     (strt_cal),
        .inertial_cal (inertial_cal),
        .cal_done     (cal_done),
        .motors_off   (motors_off)
    );

    // tx_busy only feeds the assertion inside uart_tx
    uart_tx u_tx (
        .clk       (clk),
        .rst_n     (rst_n),
        .send_resp (send_resp),
        .resp      (resp),
        .tx        (tx),
        .tx_busy   ()
    );

endmodule

// File: source/cmd_cfg.sv
`timescale 1ns/100ps
// command FSM, decodes each command into setpoints, motors-off and the calibration sequence
module cmd_cfg
    import quad_cmd_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    cmd_if.sink     cmd_port,
    output byte_t   resp,          // response byte for uart_tx
    output logic    send_resp,     // one cycle strobe to uart_tx
    output angle_t  d_ptch,
    output angle_t  d_roll,
    output angle_t  d_yaw,
    output thrust_t thrst,
    output logic    strt_cal,      // single cycle kick to the inertial unit
    output logic    inertial_cal,  // high through ramp and calibration
    input  logic    cal_done,      // from inertial unit
    output logic    motors_off     // to the ESCs
);

    cfg_state_t           state;
    cfg_state_t           next_state;
    logic                 wr_ptch;        // setpoint write enables
    logic                 wr_roll;
    logic                 wr_yaw;
    logic                 wr_thrst;
    logic                 emer_land;      // zero every setpoint
    logic                 set_motors_off;
    logic                 strt_cal_comb;  // registered below so strt_cal is glitch free
    logic [CAL_TMR_W:0]   cal_tmr;        // one extra bit marks the end of the ramp
    logic                 tmr_full;

    // only one response byte exists
    assign resp = RESP_ACK;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= IDLE;
        else
            state <= next_state;
    end

    // next state and strobes
    always_comb begin
        next_state           = state;
        cmd_port.clr_cmd_rdy = 1'b0;
        send_resp            = 1'b0;
        wr_ptch              = 1'b0;
        wr_roll              = 1'b0;
        wr_yaw               = 1'b0;
        wr_thrst             = 1'b0;
        emer_land            = 1'b0;
        set_motors_off       = 1'b0;
        strt_cal_comb        = 1'b0;
        case (state)
            RAMP_MOTORS: begin
                if (tmr_full) begin
                    strt_cal_comb = 1'b1;
                    next_state    = CAL;
                end
            end
            CAL: begin
                // ack held back until the inertial unit reports
                if (cal_done) begin
                    send_resp  = 1'b1;
                    next_state = IDLE;
                end
            end
            default: begin  // IDLE
                if (cmd_port.cmd_rdy) begin
                    cmd_port.clr_cmd_rdy = 1'b1;
                    send_resp            = 1'b1;  // immediate ack except calibrate
                    case (cmd_port.cmd)
                        SET_PTCH:  wr_ptch        = 1'b1;
                        SET_ROLL:  wr_roll        = 1'b1;
                        SET_YAW:   wr_yaw         = 1'b1;
                        SET_THRST: wr_thrst       = 1'b1;
                        MTRS_OFF:  set_motors_off = 1'b1;
                        CALIBRATE: begin
                            send_resp  = 1'b0;
                            next_state = RAMP_MOTORS;
                        end
                        default:   emer_land      = 1'b1;  // EMER_LAND or unknown opcode
                    endcase
                end
            end
        endcase
    end

    assign inertial_cal = (state != IDLE);

    // setpoint holding registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            d_ptch <= '0;
            d_roll <= '0;
            d_yaw  <= '0;
            thrst  <= '0;
        end else if (emer_land) begin
            d_ptch <= '0;
            d_roll <= '0;
            d_yaw  <= '0;
            thrst  <= '0;
        end else begin
            if (wr_ptch)
                d_ptch <= cmd_port.data;
            if (wr_roll)
                d_roll <= cmd_port.data;
            if (wr_yaw)
                d_yaw <= cmd_port.data;
            if (wr_thrst)
                thrst <= cmd_port.data[8:0];  // thrust is 9 bits
        end
    end

    // ramp timer, counts 2^CAL_TMR_W cycles from entry into RAMP_MOTORS
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            cal_tmr <= '0;
        else if (state != RAMP_MOTORS)
            cal_tmr <= '0;
        else
            cal_tmr <= cal_tmr + 1'b1;
    end

    assign tmr_full = cal_tmr[CAL_TMR_W];

    // strt_cal follows the comb strobe by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            strt_cal <= 1'b0;
        else
            strt_cal <= strt_cal_comb;
    end

    // set/reset flop, motors held off until a calibration spins them up
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            motors_off <= 1'b1;
        else if (set_motors_off)
            motors_off <= 1'b1;
        else if (inertial_cal)
            motors_off <= 1'b0;
    end

    // inertial unit expects a single cycle start
    a_strt_cal_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        strt_cal |=> !strt_cal
    ) else $error("strt_cal high for more than one cycle");

    // calibrate ack must wait for cal_done
    a_no_resp_in_ramp: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == RAMP_MOTORS) |-> !send_resp
    ) else $error("response sent during motor ramp");

endmodule

// File: source/cmd_assembler.sv
`timescale 1ns/100ps
// collects opcode, data high and data low bytes into one command for the command block
module cmd_assembler
    import quad_cmd_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  rx_rdy,      // pulse per received byte
    input  byte_t rx_data,
    cmd_if.source cmd_port
);

    logic [1:0] byte_cnt;  // which byte of the frame comes next

    // frame position and cmd_rdy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            byte_cnt         <= 2'd0;
            cmd_port.cmd_rdy <= 1'b0;
        end else if (rx_rdy) begin
            case (byte_cnt)
                2'd0: begin
                    byte_cnt         <= 2'd1;
                    cmd_port.cmd_rdy <= 1'b0;  // new frame replaces an unserved one
                end
                2'd1: byte_cnt <= 2'd2;
                default: begin
                    byte_cnt         <= 2'd0;
                    cmd_port.cmd_rdy <= 1'b1;  // frame complete
                end
            endcase
        end else if (cmd_port.clr_cmd_rdy) begin
            cmd_port.cmd_rdy <= 1'b0;
        end
    end

    // payload steering
    always_ff @(posedge clk) begin
        if (rx_rdy) begin
            case (byte_cnt)
                2'd0:    cmd_port.cmd        <= rx_data;
                2'd1:    cmd_port.data[15:8] <= rx_data;
                default: cmd_port.data[7:0]  <= rx_data;
            endcase
        end
    end

    // command block decodes over several cycles and must see a steady word
    a_cmd_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (cmd_port.cmd_rdy && $past(cmd_port.cmd_rdy)) |->
            ($stable(cmd_port.cmd) && $stable(cmd_port.data))
    ) else $error("command changed while cmd_rdy was high");

endmodule

// File: source/uart_tx.sv
`timescale 1ns/100ps
// uart transmitter, sends one response byte for each send_resp pulse
module uart_tx
    import quad_cmd_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  send_resp,  // one cycle load strobe
    input  byte_t resp,       // byte to send, taken with send_resp
    output logic  tx,         // serial out, idles high
    output logic  tx_busy     // high for the whole 10 bit frame
);

    logic [9:0]            shift_reg;  // stop, data msb..lsb, start
    logic [BAUD_CNT_W-1:0] baud_cnt;
    logic [3:0]            bit_cnt;    // bits already shifted out
    logic                  bit_end;

    assign bit_end = tx_busy && (baud_cnt == BAUD_CNT_W'(BAUD_DIV - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shift_reg <= '1;            // line idles high
            tx_busy   <= 1'b0;
            baud_cnt  <= '0;
            bit_cnt   <= '0;
        end else if (send_resp) begin
            shift_reg <= {1'b1, resp, 1'b0};  // start bit goes out first
            tx_busy   <= 1'b1;
            baud_cnt  <= '0;
            bit_cnt   <= '0;
        end else if (bit_end) begin
            shift_reg <= {1'b1, shift_reg[9:1]};  // fill with idle level
            baud_cnt  <= '0;
            bit_cnt   <= bit_cnt + 4'd1;
            if (bit_cnt == 4'd9)
                tx_busy <= 1'b0;        // stop bit finished
        end else if (tx_busy) begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    assign tx = shift_reg[0];

    // no back-pressure, the command block relies on the line being free
    a_no_send_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        send_resp |-> !tx_busy
    ) else $error("send_resp while uart_tx still busy");

endmodule

// File: source/uart_rx.sv
`timescale 1ns/100ps
// uart receiver, samples rx mid bit and pulses rx_rdy with each good byte
module uart_rx
    import quad_cmd_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  rx,        // async serial line, idles high
    output logic  rx_rdy,    // one cycle per good byte
    output byte_t rx_data    // valid with rx_rdy, held until next byte shifts in
);

    logic                  rx_ff1;      // first sync stage
    logic                  rx_ff2;      // second sync stage, safe to use
    logic                  rx_prev;     // delayed copy for edge detect
    logic                  busy;        // inside a frame
    logic [BAUD_CNT_W-1:0] baud_cnt;    // counts down to next sample point
    logic [3:0]            bit_cnt;     // 0 start, 1..8 data, 9 stop
    logic                  start_edge;
    logic                  sample;
    byte_t                 shift_reg;

    // rx comes from off chip
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_ff1  <= 1'b1;
            rx_ff2  <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_ff1  <= rx;
            rx_ff2  <= rx_ff1;
            rx_prev <= rx_ff2;
        end
    end

    assign start_edge = !busy && rx_prev && !rx_ff2;  // falling edge while idle
    assign sample     = busy && (baud_cnt == '0);

    // bit timing and frame position
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (start_edge) begin
            busy     <= 1'b1;
            baud_cnt <= BAUD_CNT_W'(BAUD_DIV / 2 - 1);  // half a bit to the start bit middle
            bit_cnt  <= '0;
        end else if (sample) begin
            baud_cnt <= BAUD_CNT_W'(BAUD_DIV - 1);      // full bit to the next middle
            bit_cnt  <= bit_cnt + 4'd1;
            if ((bit_cnt == 4'd0 && rx_ff2) || bit_cnt == 4'd9)
                busy <= 1'b0;                           // glitch start or stop bit reached
        end else if (busy) begin
            baud_cnt <= baud_cnt - 1'b1;
        end
    end

    // data comes lsb first so it enters at the top and moves down
    always_ff @(posedge clk) begin
        if (sample && bit_cnt != 4'd0 && bit_cnt != 4'd9)
            shift_reg <= {rx_ff2, shift_reg[7:1]};
    end

    // a low stop bit means a framing error, byte is dropped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            rx_rdy <= 1'b0;
        else
            rx_rdy <= sample && (bit_cnt == 4'd9) && rx_ff2;
    end

    assign rx_data = shift_reg;

endmodule

// File: source/cmd_if.sv
`timescale 1ns/100ps
// assembled command bus from the byte assembler to the command block, with its clear strobe
interface cmd_if
    import quad_cmd_pkg::*;
();

    logic      cmd_rdy;      // level, high from third byte until cleared
    opcode_t   cmd;          // stable while cmd_rdy
    cmd_data_t data;         // stable while cmd_rdy
    logic      clr_cmd_rdy;  // one cycle pulse back from the consumer

    // assembler side
    modport source (
        output cmd_rdy,
        output cmd,
        output data,
        input  clr_cmd_rdy
    );

    // command block side
    modport sink (
        input  cmd_rdy,
        input  cmd,
        input  data,
        output clr_cmd_rdy
    );

endinterface

// File: source/quad_cmd_pkg.sv
// shared types, opcodes and sizes for the quadcopter command path, imported by every rtl block
package quad_cmd_pkg;

    // uart byte and command words
    typedef logic [7:0]  byte_t;
    typedef logic [7:0]  opcode_t;      // first byte of a frame
    typedef logic [15:0] cmd_data_t;    // high byte then low byte

    // setpoints handed to the flight loops
    typedef logic [15:0] angle_t;       // pitch, roll, yaw
    typedef logic [8:0]  thrust_t;      // thrust uses low 9 bits of data

    // opcodes
    localparam opcode_t SET_PTCH  = 8'h02;
    localparam opcode_t SET_ROLL  = 8'h03;
    localparam opcode_t SET_YAW   = 8'h04;
    localparam opcode_t SET_THRST = 8'h05;
    localparam opcode_t CALIBRATE = 8'h06;
    localparam opcode_t EMER_LAND = 8'h07;  // anything unknown lands too
    localparam opcode_t MTRS_OFF  = 8'h08;

    // every command is answered with this byte
    localparam byte_t RESP_ACK = 8'hA5;

    // uart bit timing
    localparam int BAUD_DIV   = 16;                 // clocks per bit
    localparam int BAUD_CNT_W = $clog2(BAUD_DIV);   // bit timer width

    // motor ramp before calibration, short value for simulation
    localparam int CAL_TMR_W = 9;

    // command block states
    typedef enum logic [1:0] {
        IDLE,           // waiting for cmd_rdy
        RAMP_MOTORS,    // spin up before calibration
        CAL             // inertial unit calibrating
    } cfg_state_t;

endpackage
